// File: hdl/ex_pkg.sv
package ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;

    // major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // alu funct3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // srl or sra, by funct7
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // multiply funct3, div/rem codes are not executed
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // one instruction word, read as R-type or I-type
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
    } inst_u;

endpackage

// File: hdl/ex_alu.sv
`timescale 1ns/100ps

module ex_alu (
    input  logic [ex_pkg::XLEN-1:0] op_a_i,
    input  logic [ex_pkg::XLEN-1:0] op_b_i,
    input  logic [2:0]              funct3_i,
    input  logic                    alt_i,    // sub / sra
    output logic [ex_pkg::XLEN-1:0] result_o
);

    logic [ex_pkg::SHAMT_W-1:0] shamt;
    logic [ex_pkg::XLEN-1:0]    sum;
    logic [ex_pkg::XLEN-1:0]    shift_r;
    logic                       lt_s;
    logic                       lt_u;

    assign shamt = op_b_i[ex_pkg::SHAMT_W-1:0];

    assign sum = alt_i ? (op_a_i - op_b_i) : (op_a_i + op_b_i);

    // arithmetic fill only when alt is set
    assign shift_r = alt_i ? ex_pkg::XLEN'($signed(op_a_i) >>> shamt) : (op_a_i >> shamt);

    assign lt_s = $signed(op_a_i) < $signed(op_b_i);
    assign lt_u = op_a_i < op_b_i;

    always_comb begin
        case (funct3_i)
            ex_pkg::F3_ADD: begin
                result_o = sum;
            end
            ex_pkg::F3_SLL: begin
                result_o = op_a_i << shamt;
            end
            ex_pkg::F3_SLT: begin
                result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_s};
            end
            ex_pkg::F3_SLTU: begin
                result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_u};
            end
            ex_pkg::F3_XOR: begin
                result_o = op_a_i ^ op_b_i;
            end
            ex_pkg::F3_SR: begin
                result_o = shift_r;
            end
            ex_pkg::F3_OR: begin
                result_o = op_a_i | op_b_i;
            end
            default: begin
                result_o = op_a_i & op_b_i; // F3_AND
            end
        endcase
    end

endmodule

// File: hdl/ex_branch.sv
`timescale 1ns/100ps

module ex_branch (
    input  logic [ex_pkg::XLEN-1:0] rs1_i,
    input  logic [ex_pkg::XLEN-1:0] rs2_i,
    input  logic [2:0]              funct3_i,
    input  logic [ex_pkg::XLEN-1:0] base_i,
    input  logic [ex_pkg::XLEN-1:0] offset_i,
    output logic                    taken_o,
    output logic [ex_pkg::XLEN-1:0] target_o
);

    logic                    eq;
    logic                    lt_s;
    logic                    lt_u;
    logic [ex_pkg::XLEN-1:0] sum;

    assign eq   = rs1_i == rs2_i;
    assign lt_s = $signed(rs1_i) < $signed(rs2_i);
    assign lt_u = rs1_i < rs2_i;

    always_comb begin
        case (funct3_i)
            ex_pkg::F3_BEQ:  taken_o = eq;
            ex_pkg::F3_BNE:  taken_o = ~eq;
            ex_pkg::F3_BLT:  taken_o = lt_s;
            ex_pkg::F3_BGE:  taken_o = ~lt_s;
            ex_pkg::F3_BLTU: taken_o = lt_u;
            ex_pkg::F3_BGEU: taken_o = ~lt_u;
            default:         taken_o = 1'b0; // 010 and 011 are not branches
        endcase
    end

    // shared by branches, jal and jalr
    assign sum      = base_i + offset_i;
    assign target_o = {sum[ex_pkg::XLEN-1:1], 1'b0};

endmodule

// File: hdl/ex_mult.sv
`timescale 1ns/100ps

module ex_mult #(
    parameter int MUL_STEP_BITS = 2
) (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    valid_i,
    output logic                    ready_o,
    input  logic [2:0]              op_i,
    input  logic [ex_pkg::XLEN-1:0] multiplicand_i,
    input  logic [ex_pkg::XLEN-1:0] multiplier_i,
    output logic                    done_o,
    input  logic                    take_i,
    output logic [ex_pkg::XLEN-1:0] result_o
);

    localparam int STEPS = ex_pkg::XLEN / MUL_STEP_BITS;
    localparam int CNT_W = $clog2(STEPS + 1);
    localparam int PW    = 2 * ex_pkg::XLEN;

    logic             busy_q;
    logic             done_q;
    logic [CNT_W-1:0] cnt_q;
    logic [PW-1:0]    acc_q;
    logic [PW-1:0]    mcand_q;
    logic [ex_pkg::XLEN-1:0] mplier_q;
    logic             neg_q;
    logic             hi_q;
    logic [ex_pkg::XLEN-1:0] result_q;

    logic             a_neg;
    logic             b_neg;
    logic [PW-1:0]    step_sum;
    logic [PW-1:0]    product;

    // mulhu is the only fully unsigned form, mulhsu keeps b unsigned
    assign a_neg = (op_i != ex_pkg::F3_MULHU) & multiplicand_i[ex_pkg::XLEN-1];
    assign b_neg = ((op_i == ex_pkg::F3_MUL) | (op_i == ex_pkg::F3_MULH))
                   & multiplier_i[ex_pkg::XLEN-1];

    always_comb begin
        step_sum = '0;
        for (int k = 0; k < MUL_STEP_BITS; k++) begin
            if (mplier_q[k]) begin
                step_sum = step_sum + (mcand_q << k);
            end
        end
    end

    assign product = neg_q ? (~acc_q + 1'b1) : acc_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else if (valid_i && ready_o) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(STEPS);
        end else if (busy_q) begin
            if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end else begin
                busy_q <= 1'b0; // fix sign and pick the word
                done_q <= 1'b1;
            end
        end else if (done_q && take_i) begin
            done_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            acc_q    <= '0;
            mcand_q  <= {{ex_pkg::XLEN{1'b0}}, a_neg ? -multiplicand_i : multiplicand_i};
            mplier_q <= b_neg ? -multiplier_i : multiplier_i;
            neg_q    <= a_neg ^ b_neg;
            hi_q     <= op_i != ex_pkg::F3_MUL;
        end else if (busy_q && cnt_q != '0) begin
            acc_q    <= acc_q + step_sum;
            mcand_q  <= mcand_q << MUL_STEP_BITS;
            mplier_q <= mplier_q >> MUL_STEP_BITS;
        end else if (busy_q) begin
            result_q <= hi_q ? product[PW-1:ex_pkg::XLEN] : product[ex_pkg::XLEN-1:0];
        end
    end

    assign ready_o  = ~busy_q & ~done_q;
    assign done_o   = done_q;
    assign result_o = result_q;

endmodule

// File: hdl/ex_stage.sv
`timescale 1ns/100ps

module ex_stage #(
    parameter int MUL_STEP_BITS = 2
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          in_valid_i,
    output logic                          in_ready_o,
    input  ex_pkg::inst_u                 inst_i,
    input  logic [ex_pkg::XLEN-1:0]       pc_i,
    input  logic [ex_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [ex_pkg::XLEN-1:0]       rs2_data_i,
    output logic                          out_valid_o,
    input  logic                          out_ready_i,
    output logic                          rd_we_o,
    output logic [ex_pkg::REG_ADDR_W-1:0] rd_addr_o,
    output logic [ex_pkg::XLEN-1:0]       rd_data_o,
    output logic                          jump_o,
    output logic [ex_pkg::XLEN-1:0]       jump_addr_o
);

    localparam logic [ex_pkg::XLEN-1:0] INST_BYTES = 4;

    logic [ex_pkg::XLEN-1:0] raw;
    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [ex_pkg::XLEN-1:0] imm_i;
    logic [ex_pkg::XLEN-1:0] imm_b;
    logic [ex_pkg::XLEN-1:0] imm_j;
    logic                    is_op_imm;
    logic                    is_op;
    logic                    is_mul;
    logic                    is_branch;
    logic                    is_jal;
    logic                    is_jalr;

    logic [ex_pkg::XLEN-1:0] op_a;
    logic [ex_pkg::XLEN-1:0] op_b;
    logic                    alu_alt;
    logic [ex_pkg::XLEN-1:0] alu_result;
    logic                    taken;
    logic [ex_pkg::XLEN-1:0] target;

    logic                          out_free;
    logic                          in_fire;
    logic                          single;
    logic                          single_we;
    logic                          single_jump;
    logic                          mul_valid;
    logic                          mul_ready;
    logic                          mul_done;
    logic                          mul_take;
    logic                          mul_busy;
    logic [ex_pkg::XLEN-1:0]       mul_result;
    logic [ex_pkg::REG_ADDR_W-1:0] mul_rd_q;

    logic                          out_valid_q;
    logic                          rd_we_q;
    logic                          jump_q;
    logic [ex_pkg::REG_ADDR_W-1:0] rd_addr_q;
    logic [ex_pkg::XLEN-1:0]       rd_data_q;
    logic [ex_pkg::XLEN-1:0]       jump_addr_q;

    assign raw    = inst_i;
    assign opcode = inst_i.r.opcode;
    assign funct3 = inst_i.r.funct3;
    assign funct7 = inst_i.r.funct7;

    assign imm_i = {{(ex_pkg::XLEN-12){inst_i.i.imm12[11]}}, inst_i.i.imm12};
    assign imm_b = {{(ex_pkg::XLEN-12){raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
    assign imm_j = {{(ex_pkg::XLEN-20){raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};

    assign is_op_imm = opcode == ex_pkg::OPC_OP_IMM;
    assign is_op     = (opcode == ex_pkg::OPC_OP)
                       & ((funct7 == ex_pkg::F7_BASE) | (funct7 == ex_pkg::F7_ALT));
    assign is_mul    = (opcode == ex_pkg::OPC_OP) & (funct7 == ex_pkg::F7_MULDIV) & ~funct3[2];
    assign is_branch = opcode == ex_pkg::OPC_BRANCH;
    assign is_jal    = opcode == ex_pkg::OPC_JAL;
    assign is_jalr   = opcode == ex_pkg::OPC_JALR;

    assign op_a = rs1_data_i;
    assign op_b = is_op_imm ? imm_i : rs2_data_i;

    // addi never subtracts, srai takes bit 30 of imm12
    assign alu_alt = is_op ? (funct7 == ex_pkg::F7_ALT)
                           : ((funct3 == ex_pkg::F3_SR) & inst_i.i.imm12[10]);

    ex_alu u_alu (
        .op_a_i  (op_a),
        .op_b_i  (op_b),
        .funct3_i(funct3),
        .alt_i   (alu_alt),
        .result_o(alu_result)
    );

    ex_branch u_branch (
        .rs1_i   (rs1_data_i),
        .rs2_i   (rs2_data_i),
        .funct3_i(funct3),
        .base_i  (is_jalr ? rs1_data_i : pc_i),
        .offset_i(is_jalr ? imm_i : (is_jal ? imm_j : imm_b)),
        .taken_o (taken),
        .target_o(target)
    );

    assign out_free   = ~out_valid_q | out_ready_i;
    assign in_ready_o = out_free & ~mul_busy;
    assign in_fire    = in_valid_i & in_ready_o;
    assign single     = in_fire & ~is_mul;
    assign mul_valid  = in_fire & is_mul;
    assign mul_take   = mul_done & out_free;

    assign single_we   = (is_op_imm | is_op | is_jal | is_jalr) & (inst_i.r.rd != '0);
    assign single_jump = (is_branch & taken) | is_jal | is_jalr;

    ex_mult #(
        .MUL_STEP_BITS(MUL_STEP_BITS)
    ) u_mult (
        .clk_i,
        .reset_i,
        .valid_i       (mul_valid),
        .ready_o       (mul_ready),
        .op_i          (funct3),
        .multiplicand_i(op_a),
        .multiplier_i  (op_b),
        .done_o        (mul_done),
        .take_i        (mul_take),
        .result_o      (mul_result)
    );

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_valid_q <= 1'b0;
            rd_we_q     <= 1'b0;
            jump_q      <= 1'b0;
            mul_busy    <= 1'b0;
        end else begin
            if (single) begin
                out_valid_q <= 1'b1;
                rd_we_q     <= single_we;
                jump_q      <= single_jump;
            end else if (mul_take) begin
                out_valid_q <= 1'b1;
                rd_we_q     <= mul_rd_q != '0;
                jump_q      <= 1'b0;
            end else if (out_ready_i) begin
                out_valid_q <= 1'b0; // drained, nothing new
                rd_we_q     <= 1'b0;
                jump_q      <= 1'b0;
            end
            if (mul_valid) begin
                mul_busy <= 1'b1;
            end else if (mul_take) begin
                mul_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (mul_valid) begin
            mul_rd_q <= inst_i.r.rd;
        end
        if (single) begin
            rd_addr_q   <= inst_i.r.rd;
            rd_data_q   <= (is_jal | is_jalr) ? pc_i + INST_BYTES : alu_result;
            jump_addr_q <= single_jump ? target : '0;
        end else if (mul_take) begin
            rd_addr_q   <= mul_rd_q;
            rd_data_q   <= mul_result;
            jump_addr_q <= '0;
        end
    end

    assign out_valid_o = out_valid_q;
    assign rd_we_o     = rd_we_q;
    assign rd_addr_o   = rd_addr_q;
    assign rd_data_o   = rd_data_q;
    assign jump_o      = jump_q;
    assign jump_addr_o = jump_addr_q;

endmodule

// File: testbench/ex_vectors.svh
// rs1 is always x1 and rs2 is always x2 in these encodings
function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, 5'd2, 5'd1, f3, rd, ex_pkg::OPC_OP};
endfunction

function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [6:0] opc);
    return {imm, 5'd1, f3, rd, opc};
endfunction

function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], ex_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, ex_pkg::OPC_JAL};
endfunction

// columns: name, inst, pc, rs1, rs2 / rd_we, rd, rd_data, jump, jump_addr
typedef struct packed {
    logic [63:0] name;
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic        we;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        jump;
    logic [31:0] target;
} vec_t;

localparam logic [31:0] PC0 = 32'h0000_0100;
localparam int NUM_VECS = 37;

localparam vec_t VECS [NUM_VECS] = '{
    '{"add", r_word(ex_pkg::F7_BASE, ex_pkg::F3_ADD, 5'd3), PC0, 32'd5, 32'hFFFF_FFFD,
      1'b1, 5'd3, 32'd2, 1'b0, 32'd0},
    '{"sub", r_word(ex_pkg::F7_ALT, ex_pkg::F3_ADD, 5'd4), PC0, 32'd5, 32'd7,
      1'b1, 5'd4, 32'hFFFF_FFFE, 1'b0, 32'd0},
    '{"addi", i_word(12'hFFF, ex_pkg::F3_ADD, 5'd5, ex_pkg::OPC_OP_IMM), PC0, 32'h10,
      32'hDEAD_BEEF, 1'b1, 5'd5, 32'h0000_000F, 1'b0, 32'd0},
    '{"xor", r_word(ex_pkg::F7_BASE, ex_pkg::F3_XOR, 5'd6), PC0, 32'hF0F0_F0F0, 32'h0FF0_0FF0,
      1'b1, 5'd6, 32'hFF00_FF00, 1'b0, 32'd0},
    '{"mul", r_word(ex_pkg::F7_MULDIV, ex_pkg::F3_MUL, 5'd15), PC0, 32'hFFFF_FFFD, 32'd7,
      1'b1, 5'd15, 32'hFFFF_FFEB, 1'b0, 32'd0},
    '{"mulh", r_word(ex_pkg::F7_MULDIV, ex_pkg::F3_MULH, 5'd15), PC0, 32'hFFFF_FFFD,
      32'h4000_0000, 1'b1, 5'd15, 32'hFFFF_FFFF, 1'b0, 32'd0},
    '{"or", r_word(ex_pkg::F7_BASE, ex_pkg::F3_OR, 5'd7), PC0, 32'hF0F0_0000, 32'h0000_0F0F,
      1'b1, 5'd7, 32'hF0F0_0F0F, 1'b0, 32'd0},
    '{"andi", i_word(12'h0FF, ex_pkg::F3_AND, 5'd8, ex_pkg::OPC_OP_IMM), PC0, 32'h1234_5678,
      32'd0, 1'b1, 5'd8, 32'h0000_0078, 1'b0, 32'd0},
    '{"sll", r_word(ex_pkg::F7_BASE, ex_pkg::F3_SLL, 5'd9), PC0, 32'd3, 32'h24,
      1'b1, 5'd9, 32'h30, 1'b0, 32'd0},
    '{"srl", r_word(ex_pkg::F7_BASE, ex_pkg::F3_SR, 5'd10), PC0, 32'h8000_0000, 32'd4,
      1'b1, 5'd10, 32'h0800_0000, 1'b0, 32'd0},
    '{"sra", r_word(ex_pkg::F7_ALT, ex_pkg::F3_SR, 5'd11), PC0, 32'h8000_0000, 32'd4,
      1'b1, 5'd11, 32'hF800_0000, 1'b0, 32'd0},
    '{"srai", i_word(12'h408, ex_pkg::F3_SR, 5'd12, ex_pkg::OPC_OP_IMM), PC0, 32'hFFFF_0000,
      32'd0, 1'b1, 5'd12, 32'hFFFF_FF00, 1'b0, 32'd0},
    '{"slt", r_word(ex_pkg::F7_BASE, ex_pkg::F3_SLT, 5'd13), PC0, 32'hFFFF_FFFF, 32'd1,
      1'b1, 5'd13, 32'd1, 1'b0, 32'd0},
    '{"sltu", r_word(ex_pkg::F7_BASE, ex_pkg::F3_SLTU, 5'd14), PC0, 32'hFFFF_FFFF, 32'd1,
      1'b1, 5'd14, 32'd0, 1'b0, 32'd0},
    '{"mulh_min", r_word(ex_pkg::F7_MULDIV, ex_pkg::F3_MULH, 5'd15), PC0, 32'h8000_0000,
      32'h8000_0000, 1'b1, 5'd15, 32'h4000_0000, 1'b0, 32'd0},
    '{"beq_t", b_word(13'h010, ex_pkg::F3_BEQ), PC0, 32'd7, 32'd7,
      1'b0, 5'd0, 32'd0, 1'b1, 32'h110},
    '{"beq_n", b_word(13'h010, ex_pkg::F3_BEQ), PC0, 32'd7, 32'd8,
      1'b0, 5'd0, 32'd0, 1'b0, 32'd0},
    '{"bne_t", b_word(13'h010, ex_pkg::F3_BNE), PC0, 32'd7, 32'd8,
      1'b0, 5'd0, 32'd0, 1'b1, 32'h110},
    '{"bne_n", b_word(13'h010, ex_pkg::F3_BNE), PC0, 32'd7, 32'd7,
      1'b0, 5'd0, 32'd0, 1'b0, 32'd0},
    '{"blt_t", b_word(13'h1FF8, ex_pkg::F3_BLT), PC0, 32'hFFFF_FFFF, 32'd1,
      1'b0, 5'd0, 32'd0, 1'b1, 32'hF8},
    '{"blt_n", b_word(13'h1FF8, ex_pkg::F3_BLT), PC0, 32'd1, 32'hFFFF_FFFF,
      1'b0, 5'd0, 32'd0, 1'b0, 32'd0},
    '{"bge_t", b_word(13'h1FF8, ex_pkg::F3_BGE), PC0, 32'd1, 32'hFFFF_FFFF,
      1'b0, 5'd0, 32'd0, 1'b1, 32'hF8},
    '{"bge_n", b_word(13'h1FF8, ex_pkg::F3_BGE), PC0, 32'hFFFF_FFFF, 32'd1,
      1'b0, 5'd0, 32'd0, 1'b0, 32'd0},
    '{"bltu_t", b_word(13'h020, ex_pkg::F3_BLTU), PC0, 32'd1, 32'hFFFF_FFFF,
      1'b0, 5'd0, 32'd0, 1'b1, 32'h120},
    '{"bltu_n", b_word(13'h020, ex_pkg::F3_BLTU), PC0, 32'hFFFF_FFFF, 32'd1,
      1'b0, 5'd0, 32'd0, 1'b0, 32'd0},
    '{"bgeu_t", b_word(13'h020, ex_pkg::F3_BGEU), PC0, 32'hFFFF_FFFF, 32'd1,
      1'b0, 5'd0, 32'd0, 1'b1, 32'h120},
    '{"bgeu_n", b_word(13'h020, ex_pkg::F3_BGEU), PC0, 32'd1, 32'hFFFF_FFFF,
      1'b0, 5'd0, 32'd0, 1'b0, 32'd0},
    '{"mulhsu", r_word(ex_pkg::F7_MULDIV, ex_pkg::F3_MULHSU, 5'd15), PC0, 32'hFFFF_FFFF,
      32'hFFFF_FFFF, 1'b1, 5'd15, 32'hFFFF_FFFF, 1'b0, 32'd0},
    '{"jal", j_word(21'h01_2346, 5'd1), PC0, 32'd0, 32'd0,
      1'b1, 5'd1, 32'h104, 1'b1, 32'h0001_2446},
    '{"jal_neg", j_word(21'h1F_FF00, 5'd5), 32'h2000, 32'd0, 32'd0,
      1'b1, 5'd5, 32'h2004, 1'b1, 32'h1F00},
    '{"jalr", i_word(12'hFF0, 3'b000, 5'd1, ex_pkg::OPC_JALR), PC0, 32'h3001, 32'd0,
      1'b1, 5'd1, 32'h104, 1'b1, 32'h2FF0},
    '{"mulhu", r_word(ex_pkg::F7_MULDIV, ex_pkg::F3_MULHU, 5'd15), PC0, 32'hFFFF_FFFF,
      32'hFFFF_FFFF, 1'b1, 5'd15, 32'hFFFF_FFFE, 1'b0, 32'd0},
    '{"mulhsu_u", r_word(ex_pkg::F7_MULDIV, ex_pkg::F3_MULHSU, 5'd15), PC0, 32'd2,
      32'h8000_0000, 1'b1, 5'd15, 32'd1, 1'b0, 32'd0},
    '{"div", r_word(ex_pkg::F7_MULDIV, 3'b100, 5'd16), PC0, 32'd9, 32'd3,
      1'b0, 5'd0, 32'd0, 1'b0, 32'd0},
    '{"load", i_word(12'h010, 3'b010, 5'd17, 7'b0000011), PC0, 32'h4000, 32'd0,
      1'b0, 5'd0, 32'd0, 1'b0, 32'd0},
    '{"add_x0", r_word(ex_pkg::F7_BASE, ex_pkg::F3_ADD, 5'd0), PC0, 32'd1, 32'd2,
      1'b0, 5'd0, 32'd0, 1'b0, 32'd0},
    '{"mul_x0", r_word(ex_pkg::F7_MULDIV, ex_pkg::F3_MUL, 5'd0), PC0, 32'd3, 32'd4,
      1'b0, 5'd0, 32'd0, 1'b0, 32'd0}
};

// File: testbench/ex_checker.sv
`timescale 1ns/100ps

module ex_checker (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          out_valid_i,
    input  logic                          out_ready_i,
    input  logic                          rd_we_i,
    input  logic [ex_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic [ex_pkg::XLEN-1:0]       rd_data_i,
    input  logic                          jump_i,
    input  logic [ex_pkg::XLEN-1:0]       jump_addr_i,
    output int                            checked_o,
    output int                            errors_o
);

    `include "ex_vectors.svh"

    int checked = 0;
    int errors  = 0;

    assign checked_o = checked;
    assign errors_o  = errors;

    // one result per output handshake, matched to the table in order
    always @(posedge clk_i) begin : compare
        vec_t want;
        int   bad;
        if (!reset_i && out_valid_i && out_ready_i) begin
            if (checked >= NUM_VECS) begin
                $display("result %0d came out after the last test was done", checked + 1);
                errors = errors + 1;
            end else begin
                want = VECS[checked];
                bad  = 0;
                if (rd_we_i !== want.we) begin
                    $display("Error %s: rd_we expected %0b actual %0b", want.name, want.we, rd_we_i);
                    bad++;
                end
                if (want.we && rd_addr_i !== want.rd) begin
                    $display("Error %s: rd_addr expected %0d actual %0d",
                             want.name, want.rd, rd_addr_i);
                    bad++;
                end
                if (want.we && rd_data_i !== want.data) begin
                    $display("Error %s: rd_data expected %h actual %h",
                             want.name, want.data, rd_data_i);
                    bad++;
                end
                if (jump_i !== want.jump) begin
                    $display("Error %s: jump expected %0b actual %0b", want.name, want.jump, jump_i);
                    bad++;
                end
                if (want.jump && jump_addr_i !== want.target) begin
                    $display("Error %s: jump_addr expected %h actual %h",
                             want.name, want.target, jump_addr_i);
                    bad++;
                end
                $display("test %0d %s: %s", checked, want.name, (bad == 0) ? "ok" : "mismatch");
                errors = errors + bad;
            end
            checked = checked + 1;
        end
    end

endmodule

// File: testbench/ex_stage_properties.sv
`timescale 1ns/100ps

module ex_stage_properties (
    input logic                          clk_i,
    input logic                          reset_i,
    input logic                          in_ready_i,
    input logic                          mul_ready_i,
    input logic                          out_valid_i,
    input logic                          out_ready_i,
    input logic                          rd_we_i,
    input logic [ex_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input logic [ex_pkg::XLEN-1:0]       rd_data_i,
    input logic                          jump_i,
    input logic [ex_pkg::XLEN-1:0]       jump_addr_i
);

    hold_when_stalled: assert property (@(posedge clk_i) disable iff (reset_i)
        out_valid_i && !out_ready_i |=> out_valid_i
            && $stable({rd_we_i, rd_addr_i, rd_data_i, jump_i, jump_addr_i}))
        else $error("stage output changed while the consumer stalled it");

    empty_after_reset: assert property (@(posedge clk_i) reset_i |=> !out_valid_i)
        else $error("out_valid high right after reset");

    // the multiplier's own idle flag against the stage's input gate
    blocked_during_mul: assert property (@(posedge clk_i) disable iff (reset_i)
        !mul_ready_i |-> !in_ready_i)
        else $error("input ready while the multiplier is busy");

    no_stray_jump: assert property (@(posedge clk_i) disable iff (reset_i)
        !out_valid_i |-> !jump_i)
        else $error("jump high with no valid result");

endmodule

bind ex_stage ex_stage_properties props (
    .clk_i,
    .reset_i,
    .in_ready_i (in_ready_o),
    .mul_ready_i(mul_ready),
    .out_valid_i(out_valid_o),
    .out_ready_i,
    .rd_we_i    (rd_we_o),
    .rd_addr_i  (rd_addr_o),
    .rd_data_i  (rd_data_o),
    .jump_i     (jump_o),
    .jump_addr_i(jump_addr_o)
);

// File: testbench/tb_ex_stage.sv
`timescale 1ns/100ps

module tb_ex_stage;

    `include "ex_vectors.svh"

    localparam int MUL_STEP_BITS = 2;
    localparam int CYCLE_LIMIT   = NUM_VECS * (ex_pkg::XLEN / MUL_STEP_BITS + 4) * 4;

    logic                          clk;
    logic                          reset;
    logic                          in_valid;
    logic                          in_ready;
    ex_pkg::inst_u                 inst;
    logic [ex_pkg::XLEN-1:0]       pc;
    logic [ex_pkg::XLEN-1:0]       rs1_data;
    logic [ex_pkg::XLEN-1:0]       rs2_data;
    logic                          out_valid;
    logic                          out_ready = 1'b0;
    logic                          rd_we;
    logic [ex_pkg::REG_ADDR_W-1:0] rd_addr;
    logic [ex_pkg::XLEN-1:0]       rd_data;
    logic                          jump;
    logic [ex_pkg::XLEN-1:0]       jump_addr;

    logic [15:0] lfsr_state = 16'd27;
    int          checked;
    int          errors;
    int          cycles;

    // 16-bit galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] next_lfsr(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin : backpressure
        logic [15:0] nxt;
        nxt = next_lfsr(lfsr_state);
        lfsr_state <= nxt;
        out_ready  <= nxt[0];
    end

    initial begin : drive
        int idx;
        reset    = 1'b1;
        in_valid = 1'b0;
        inst     = '0;
        pc       = '0;
        rs1_data = '0;
        rs2_data = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (idx = 0; idx < NUM_VECS; idx++) begin
            in_valid <= 1'b1;
            inst     <= VECS[idx].inst;
            pc       <= VECS[idx].pc;
            rs1_data <= VECS[idx].rs1;
            rs2_data <= VECS[idx].rs2;
            @(posedge clk);
            while (!in_ready) @(posedge clk); // held until accepted
        end
        in_valid <= 1'b0;
    end

    ex_stage #(
        .MUL_STEP_BITS(MUL_STEP_BITS)
    ) dut (
        .clk_i      (clk),
        .reset_i    (reset),
        .in_valid_i (in_valid),
        .in_ready_o (in_ready),
        .inst_i     (inst),
        .pc_i       (pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .out_valid_o(out_valid),
        .out_ready_i(out_ready),
        .rd_we_o    (rd_we),
        .rd_addr_o  (rd_addr),
        .rd_data_o  (rd_data),
        .jump_o     (jump),
        .jump_addr_o(jump_addr)
    );

    ex_checker result_check (
        .clk_i      (clk),
        .reset_i    (reset),
        .out_valid_i(out_valid),
        .out_ready_i(out_ready),
        .rd_we_i    (rd_we),
        .rd_addr_i  (rd_addr),
        .rd_data_i  (rd_data),
        .jump_i     (jump),
        .jump_addr_i(jump_addr),
        .checked_o  (checked),
        .errors_o   (errors)
    );

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, only %0d of %0d results came out",
                 cycles, checked, NUM_VECS);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : finish_run
        wait (checked >= NUM_VECS);
        repeat (10) @(posedge clk); // catch any extra result
        $display("tests checked %0d of %0d, errors %0d", checked, NUM_VECS, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: build.f
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_branch.sv
hdl/ex_mult.sv
hdl/ex_stage.sv
+incdir+testbench
testbench/ex_checker.sv
testbench/ex_stage_properties.sv
testbench/tb_ex_stage.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f build.f --top-module tb_ex_stage

# a crash or a failed assertion stops the script here
./obj_dir/Vtb_ex_stage > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0
